/* hdl/apb_uart_bridge.sv */
/*
  Bridge from one peripheral bus port to an APB slave (the UART).
  Runs setup and access phases, waits on pready, returns slverr as err.
*/

`timescale 1ns/1ps
`default_nettype none

module apb_uart_bridge import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  periph_bus_if.slave bus,
  output logic      uart_psel_o,
  output logic      uart_penable_o,
  output logic      uart_pwrite_o,
  output soc_addr_t uart_paddr_o,
  output soc_data_t uart_pwdata_o,
  input  soc_data_t uart_prdata_i,
  input  logic      uart_pready_i,
  input  logic      uart_pslverr_i
);

  apb_state_e state_q;
  apb_state_e state_d;
  logic       accept;
  logic       done;
  logic       ack_q;
  logic       err_q;
  logic       pwrite_q;
  soc_addr_t  paddr_q;
  soc_data_t  pwdata_q;
  soc_data_t  rdata_q;

  // Hold off while our own ack is still on the bus
  assign accept = bus.req & ~ack_q & (state_q == APB_IDLE);
  assign done   = (state_q == APB_ACCESS) & uart_pready_i;

  //////////////////////////////////////////////////////////////////////
  // Phase FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      APB_IDLE:   if (accept) state_d = APB_SETUP;
      APB_SETUP:  state_d = APB_ACCESS;
      APB_ACCESS: if (uart_pready_i) state_d = APB_IDLE;
      default:    state_d = APB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= APB_IDLE;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= done;
      err_q   <= done & uart_pslverr_i;
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      paddr_q  <= bus.addr;
      pwdata_q <= bus.wdata;
      pwrite_q <= bus.we;
    end
    if (done) begin
      rdata_q <= uart_prdata_i;
    end
  end

  assign uart_psel_o    = (state_q != APB_IDLE);
  assign uart_penable_o = (state_q == APB_ACCESS);
  assign uart_pwrite_o  = pwrite_q;
  assign uart_paddr_o   = paddr_q;
  assign uart_pwdata_o  = pwdata_q;

  assign bus.rdata = rdata_q;
  assign bus.ack   = ack_q;
  assign bus.err   = err_q;

endmodule

`default_nettype wire

/* hdl/ctrl_regs.sv */
/*
  Control and status registers: exit code, counter enable, event trigger,
  and the read-only bounds of the DRAM window.
*/

`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module ctrl_regs import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  periph_bus_if.slave bus,
  output soc_data_t exit_o,
  output soc_data_t hw_cnt_en_o,
  output soc_data_t event_trigger_o
);

  ctrl_reg_e reg_sel;
  logic      accept;
  logic      ack_q;
  soc_data_t rdata_mux;
  soc_data_t rdata_q;
  soc_data_t exit_q;
  soc_data_t hw_cnt_en_q;
  soc_data_t event_q;

  function automatic soc_data_t merge_bytes(input soc_data_t old_val,
                                            input soc_data_t new_val,
                                            input soc_sel_t  sel);
    soc_data_t res;
    res = old_val;
    for (int b = 0; b < $bits(soc_sel_t); b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  always_comb begin
    case (bus.addr)
      `CTRL_EXIT_OFS:      reg_sel = CTRL_EXIT;
      `CTRL_HWCNT_OFS:     reg_sel = CTRL_HWCNT;
      `CTRL_EVENT_OFS:     reg_sel = CTRL_EVENT;
      `CTRL_DRAM_BASE_OFS: reg_sel = CTRL_DRAM_BASE;
      `CTRL_DRAM_END_OFS:  reg_sel = CTRL_DRAM_END;
      default:             reg_sel = CTRL_NONE;
    endcase
  end

  always_comb begin
    case (reg_sel)
      CTRL_EXIT:      rdata_mux = exit_q;
      CTRL_HWCNT:     rdata_mux = hw_cnt_en_q;
      CTRL_EVENT:     rdata_mux = event_q;
      CTRL_DRAM_BASE: rdata_mux = `SOC_DRAM_BASE;
      CTRL_DRAM_END:  rdata_mux = (`SOC_DRAM_BASE + `SOC_DRAM_LEN);
      default:        rdata_mux = '0;
    endcase
  end

  assign accept = bus.req & ~ack_q;

  // Read-only and unknown offsets drop writes
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_q      <= '0;
      hw_cnt_en_q <= '0;
      event_q     <= '0;
      ack_q       <= 1'b0;
    end else begin
      ack_q <= accept;
      if (accept && bus.we) begin
        case (reg_sel)
          CTRL_EXIT:  exit_q      <= merge_bytes(exit_q, bus.wdata, bus.sel);
          CTRL_HWCNT: hw_cnt_en_q <= merge_bytes(hw_cnt_en_q, bus.wdata, bus.sel);
          CTRL_EVENT: event_q     <= merge_bytes(event_q, bus.wdata, bus.sel);
          default:    ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= rdata_mux;
    end
  end

  assign bus.rdata       = rdata_q;
  assign bus.ack         = ack_q;
  assign bus.err         = 1'b0;
  assign exit_o          = exit_q;
  assign hw_cnt_en_o     = hw_cnt_en_q;
  assign event_trigger_o = event_q;

endmodule

`default_nettype wire

/* hdl/l2_mem.sv */
/*
  On-chip L2 memory behind one peripheral bus port.
  Word addressed, byte-select writes, ack one cycle after the request.
*/

`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module l2_mem import soc_pkg::*; (
  input  logic clk_i,
  input  logic arst_n_i,
  periph_bus_if.slave bus
);

  localparam int unsigned idx_w = $clog2(`SOC_L2_WORDS);

  soc_data_t        mem_q [`SOC_L2_WORDS];
  soc_data_t        rdata_q;
  logic [idx_w-1:0] idx;
  logic             accept;
  logic             ack_q;

  // Byte offset to word index
  assign idx    = bus.addr[idx_w+1:2];
  assign accept = bus.req & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (accept && bus.we) begin
      for (int b = 0; b < $bits(soc_sel_t); b++) begin
        if (bus.sel[b]) begin
          mem_q[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
    if (accept && !bus.we) begin
      rdata_q <= mem_q[idx];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;

endmodule

`default_nettype wire

/* hdl/mini_soc.sv */
/*
  Top level of the mini SoC: Wishbone classic slave port in, UART APB out,
  control outputs from the register block. Wiring only.
*/

`timescale 1ns/1ps
`default_nettype none

module mini_soc import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Wishbone classic slave port
  input  logic      wb_cyc_i,
  input  logic      wb_stb_i,
  input  logic      wb_we_i,
  input  soc_addr_t wb_adr_i,
  input  soc_data_t wb_dat_i,
  input  soc_sel_t  wb_sel_i,
  output soc_data_t wb_dat_o,
  output logic      wb_ack_o,
  output logic      wb_err_o,
  // UART APB master port
  output logic      uart_psel_o,
  output logic      uart_penable_o,
  output logic      uart_pwrite_o,
  output soc_addr_t uart_paddr_o,
  output soc_data_t uart_pwdata_o,
  input  soc_data_t uart_prdata_i,
  input  logic      uart_pready_i,
  input  logic      uart_pslverr_i,
  // Control outputs
  output soc_data_t exit_o,
  output soc_data_t hw_cnt_en_o,
  output soc_data_t event_trigger_o
);

  periph_bus_if bus_l2 ();
  periph_bus_if bus_ctrl ();
  periph_bus_if bus_uart ();

  //////////////////////////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////////////////////////

  soc_xbar i_xbar (
    .clk_i    (clk_i   ),
    .arst_n_i (arst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i ),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .l2_bus   (bus_l2  ),
    .ctrl_bus (bus_ctrl),
    .uart_bus (bus_uart)
  );

  //////////////////////////////////////////////////////////////////////
  // Memory and registers
  //////////////////////////////////////////////////////////////////////

  l2_mem i_l2_mem (
    .clk_i    (clk_i   ),
    .arst_n_i (arst_n_i),
    .bus      (bus_l2  )
  );

  ctrl_regs i_ctrl_regs (
    .clk_i           (clk_i          ),
    .arst_n_i        (arst_n_i       ),
    .bus             (bus_ctrl       ),
    .exit_o          (exit_o         ),
    .hw_cnt_en_o     (hw_cnt_en_o    ),
    .event_trigger_o (event_trigger_o)
  );

  // UART side
  apb_uart_bridge i_uart_bridge (
    .clk_i          (clk_i         ),
    .arst_n_i       (arst_n_i      ),
    .bus            (bus_uart      ),
    .uart_psel_o    (uart_psel_o   ),
    .uart_penable_o (uart_penable_o),
    .uart_pwrite_o  (uart_pwrite_o ),
    .uart_paddr_o   (uart_paddr_o  ),
    .uart_pwdata_o  (uart_pwdata_o ),
    .uart_prdata_i  (uart_prdata_i ),
    .uart_pready_i  (uart_pready_i ),
    .uart_pslverr_i (uart_pslverr_i)
  );

endmodule

`default_nettype wire

/* hdl/periph_bus_if.sv */
/*
  Request/acknowledge bus from the crossbar to one peripheral.
  The crossbar holds req until ack; err is only valid together with ack.
*/

`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if import soc_pkg::*; ();

  logic      req;
  logic      we;
  soc_addr_t addr;   // offset inside the region
  soc_data_t wdata;
  soc_sel_t  sel;
  soc_data_t rdata;
  logic      ack;
  logic      err;

  modport master (
    output req, we, addr, wdata, sel,
    input  rdata, ack, err
  );

  modport slave (
    input  req, we, addr, wdata, sel,
    output rdata, ack, err
  );

endinterface

`default_nettype wire

/* hdl/soc_params.svh */
/*
  Widths, memory map and control register offsets of the mini SoC.
  Included by the package and by every module that decodes addresses.
*/

`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Data path
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_SEL_W  (`SOC_DATA_W / 8)

// L2 storage depth in words
`define SOC_L2_WORDS 1024

// Memory map, 4 KB per region
`define SOC_DRAM_BASE 32'h8000_0000
`define SOC_DRAM_LEN  32'h0000_1000
`define SOC_UART_BASE 32'hC000_0000
`define SOC_UART_LEN  32'h0000_1000
`define SOC_CTRL_BASE 32'hD000_0000
`define SOC_CTRL_LEN  32'h0000_1000

// Control register offsets
`define CTRL_EXIT_OFS      32'h0000_0000
`define CTRL_HWCNT_OFS     32'h0000_0004
`define CTRL_EVENT_OFS     32'h0000_0008
`define CTRL_DRAM_BASE_OFS 32'h0000_000C
`define CTRL_DRAM_END_OFS  32'h0000_0010

`endif

/* hdl/soc_pkg.sv */
/*
  Types and encodings shared across the mini SoC.
  Modules take them with a wildcard import in their header.
*/

`default_nettype none

`include "soc_params.svh"

package soc_pkg;

  typedef logic [`SOC_ADDR_W-1:0] soc_addr_t;
  typedef logic [`SOC_DATA_W-1:0] soc_data_t;
  typedef logic [`SOC_SEL_W-1:0]  soc_sel_t;

  // Crossbar target
  typedef enum logic [1:0] {
    REGION_L2   = 2'd0,
    REGION_UART = 2'd1,
    REGION_CTRL = 2'd2,
    REGION_NONE = 2'd3
  } soc_region_e;

  // APB transfer phase
  typedef enum logic [1:0] {
    APB_IDLE   = 2'd0,
    APB_SETUP  = 2'd1,
    APB_ACCESS = 2'd2
  } apb_state_e;

  typedef enum logic [2:0] {
    CTRL_EXIT      = 3'd0,
    CTRL_HWCNT     = 3'd1,
    CTRL_EVENT     = 3'd2,
    CTRL_DRAM_BASE = 3'd3,
    CTRL_DRAM_END  = 3'd4,
    CTRL_NONE      = 3'd7
  } ctrl_reg_e;

endpackage

`default_nettype wire

/* hdl/soc_xbar.sv */
/*
  Address crossbar between the Wishbone classic master and the three
  peripheral buses. Unmapped addresses are answered here with an error.
*/

`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module soc_xbar import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      wb_cyc_i,
  input  logic      wb_stb_i,
  input  logic      wb_we_i,
  input  soc_addr_t wb_adr_i,
  input  soc_data_t wb_dat_i,
  input  soc_sel_t  wb_sel_i,
  output soc_data_t wb_dat_o,
  output logic      wb_ack_o,
  output logic      wb_err_o,
  periph_bus_if.master l2_bus,
  periph_bus_if.master ctrl_bus,
  periph_bus_if.master uart_bus
);

  soc_region_e region;
  soc_addr_t   offset;
  logic        valid;
  logic        done_q;
  logic        none_err_q;
  soc_data_t   sel_rdata;
  logic        sel_ack;
  logic        sel_err;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    region = REGION_NONE;
    offset = '0;
    if (wb_adr_i >= (`SOC_DRAM_BASE) && wb_adr_i < (`SOC_DRAM_BASE + `SOC_DRAM_LEN)) begin
      region = REGION_L2;
      offset = wb_adr_i - (`SOC_DRAM_BASE);
    end else if (wb_adr_i >= (`SOC_UART_BASE) &&
                 wb_adr_i < (`SOC_UART_BASE + `SOC_UART_LEN)) begin
      region = REGION_UART;
      offset = wb_adr_i - (`SOC_UART_BASE);
    end else if (wb_adr_i >= (`SOC_CTRL_BASE) &&
                 wb_adr_i < (`SOC_CTRL_BASE + `SOC_CTRL_LEN)) begin
      region = REGION_CTRL;
      offset = wb_adr_i - (`SOC_CTRL_BASE);
    end
  end

  // No new request in the cycle right after a pulse
  assign valid = wb_cyc_i & wb_stb_i & ~done_q;

  assign l2_bus.req   = valid & (region == REGION_L2);
  assign l2_bus.we    = wb_we_i;
  assign l2_bus.addr  = offset;
  assign l2_bus.wdata = wb_dat_i;
  assign l2_bus.sel   = wb_sel_i;

  assign ctrl_bus.req   = valid & (region == REGION_CTRL);
  assign ctrl_bus.we    = wb_we_i;
  assign ctrl_bus.addr  = offset;
  assign ctrl_bus.wdata = wb_dat_i;
  assign ctrl_bus.sel   = wb_sel_i;

  assign uart_bus.req   = valid & (region == REGION_UART);
  assign uart_bus.we    = wb_we_i;
  assign uart_bus.addr  = offset;
  assign uart_bus.wdata = wb_dat_i;
  assign uart_bus.sel   = wb_sel_i;

  //////////////////////////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    sel_rdata = '0;
    sel_ack   = 1'b0;
    sel_err   = 1'b0;
    case (region)
      REGION_L2: begin
        sel_rdata = l2_bus.rdata;
        sel_ack   = l2_bus.ack;
        sel_err   = l2_bus.err;
      end
      REGION_CTRL: begin
        sel_rdata = ctrl_bus.rdata;
        sel_ack   = ctrl_bus.ack;
        sel_err   = ctrl_bus.err;
      end
      REGION_UART: begin
        sel_rdata = uart_bus.rdata;
        sel_ack   = uart_bus.ack;
        sel_err   = uart_bus.err;
      end
      default: begin
        sel_ack = none_err_q;
        sel_err = none_err_q;
      end
    endcase
  end

  assign wb_dat_o = sel_rdata;
  assign wb_ack_o = sel_ack & ~sel_err;
  assign wb_err_o = sel_ack & sel_err;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q     <= 1'b0;
      none_err_q <= 1'b0;
    end else begin
      done_q     <= sel_ack;
      none_err_q <= valid & (region == REGION_NONE) & ~none_err_q;
    end
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+hdl
hdl/soc_pkg.sv
hdl/periph_bus_if.sv
hdl/soc_xbar.sv
hdl/l2_mem.sv
hdl/ctrl_regs.sv
hdl/apb_uart_bridge.sv
hdl/mini_soc.sv
test/tb_apb_uart_model.sv
test/tb_mini_soc.sv

/* test/tb_apb_uart_model.sv */
/*
  APB slave model of the UART register file for the mini SoC testbench.
  16 word registers, 0 to 3 random wait states, slave error from 0x40 up.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_apb_uart_model import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  soc_addr_t paddr_i,
  input  soc_data_t pwdata_i,
  output soc_data_t prdata_o,
  output logic      pready_o,
  output logic      pslverr_o
);

  soc_data_t   regs_q [16];
  soc_data_t   rdata_q;
  logic        ready_q;
  logic        slverr_q;
  int unsigned wait_q;
  logic        bad_addr;

  assign bad_addr = (paddr_i >= 32'h40);

  // Responses change on the falling edge, the bridge samples on the rising one
  always @(negedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 16; i++) begin
        regs_q[i] <= 32'hA000_0000 | (i << 2);
      end
      rdata_q  <= '0;
      ready_q  <= 1'b0;
      slverr_q <= 1'b0;
      wait_q   <= 0;
    end else if (psel_i && !penable_i) begin
      // Setup phase picks the wait states of this transfer
      wait_q   <= $urandom % 4;
      ready_q  <= 1'b0;
      slverr_q <= 1'b0;
    end else if (psel_i && penable_i) begin
      if (wait_q == 0) begin
        ready_q  <= 1'b1;
        slverr_q <= bad_addr;
        rdata_q  <= bad_addr ? '0 : regs_q[paddr_i[5:2]];
        if (pwrite_i && !bad_addr) begin
          regs_q[paddr_i[5:2]] <= pwdata_i;
        end
      end else begin
        wait_q <= wait_q - 1;
      end
    end else begin
      ready_q  <= 1'b0;
      slverr_q <= 1'b0;
    end
  end

  // Quiet outputs while reset is held
  assign pready_o  = arst_n_i & ready_q;
  assign pslverr_o = arst_n_i & slverr_q;
  assign prdata_o  = arst_n_i ? rdata_q : '0;

endmodule

`default_nettype wire

/* test/tb_mini_soc.sv */
/*
  Testbench for the mini SoC. Runs Wishbone transfers to L2, control
  registers, the UART model and unmapped space, and checks each response
  against shadow models of all targets.
*/

`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module tb_mini_soc import soc_pkg::*; ();

  localparam int L2_OPS   = 200;
  localparam int UART_OPS = 52;
  // Three cycles per fast transfer, at most nine per UART transfer, 2x margin
  localparam int TIMEOUT_CYCLES = 2 * (L2_OPS * 2 * 3 + UART_OPS * 9) + 600;

  logic      clk;
  logic      arst_n;
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_we;
  soc_addr_t wb_adr;
  soc_data_t wb_wdat;
  soc_sel_t  wb_sel;
  soc_data_t wb_rdat;
  logic      wb_ack;
  logic      wb_err;
  logic      uart_psel;
  logic      uart_penable;
  logic      uart_pwrite;
  soc_addr_t uart_paddr;
  soc_data_t uart_pwdata;
  soc_data_t uart_prdata;
  logic      uart_pready;
  logic      uart_pslverr;
  soc_data_t exit_val;
  soc_data_t hw_cnt_en;
  soc_data_t event_trigger;

  // Shadow models
  soc_data_t l2_shadow [`SOC_L2_WORDS];
  logic      l2_valid [`SOC_L2_WORDS];
  soc_data_t ctrl_shadow [3];
  soc_data_t uart_shadow [16];

  // Result of the last transfer, handed to the checker
  logic      act_ack;
  logic      act_err;
  logic      act_late;
  soc_data_t act_data;
  int        act_cycles;
  logic      exp_err;
  soc_data_t exp_data;
  int        exp_cycles;
  logic      exp_psel;
  logic      xfer_we;
  soc_addr_t xfer_adr;
  int        stall_cnt = 0;
  int        psel_cnt = 0;
  int        cycle_cnt = 0;
  int        errors = 0;
  event      xfer_done;

  mini_soc i_dut (
    .clk_i           (clk          ),
    .arst_n_i        (arst_n       ),
    .wb_cyc_i        (wb_cyc       ),
    .wb_stb_i        (wb_stb       ),
    .wb_we_i         (wb_we        ),
    .wb_adr_i        (wb_adr       ),
    .wb_dat_i        (wb_wdat      ),
    .wb_sel_i        (wb_sel       ),
    .wb_dat_o        (wb_rdat      ),
    .wb_ack_o        (wb_ack       ),
    .wb_err_o        (wb_err       ),
    .uart_psel_o     (uart_psel    ),
    .uart_penable_o  (uart_penable ),
    .uart_pwrite_o   (uart_pwrite  ),
    .uart_paddr_o    (uart_paddr   ),
    .uart_pwdata_o   (uart_pwdata  ),
    .uart_prdata_i   (uart_prdata  ),
    .uart_pready_i   (uart_pready  ),
    .uart_pslverr_i  (uart_pslverr ),
    .exit_o          (exit_val     ),
    .hw_cnt_en_o     (hw_cnt_en    ),
    .event_trigger_o (event_trigger)
  );

  tb_apb_uart_model i_uart_model (
    .clk_i     (clk         ),
    .arst_n_i  (arst_n      ),
    .psel_i    (uart_psel   ),
    .penable_i (uart_penable),
    .pwrite_i  (uart_pwrite ),
    .paddr_i   (uart_paddr  ),
    .pwdata_i  (uart_pwdata ),
    .prdata_o  (uart_prdata ),
    .pready_o  (uart_pready ),
    .pslverr_o (uart_pslverr)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the test did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

  // APB activity seen by the bridge at each rising edge
  always @(posedge clk) begin
    if (uart_penable && !uart_pready) begin
      stall_cnt++;
    end
    if (uart_psel) begin
      psel_cnt++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic soc_region_e region_of(input soc_addr_t adr);
    if (adr >= `SOC_DRAM_BASE && adr < `SOC_DRAM_BASE + `SOC_DRAM_LEN) begin
      return REGION_L2;
    end
    if (adr >= `SOC_UART_BASE && adr < `SOC_UART_BASE + `SOC_UART_LEN) begin
      return REGION_UART;
    end
    if (adr >= `SOC_CTRL_BASE && adr < `SOC_CTRL_BASE + `SOC_CTRL_LEN) begin
      return REGION_CTRL;
    end
    return REGION_NONE;
  endfunction

  function automatic soc_addr_t offset_of(input soc_addr_t adr);
    case (region_of(adr))
      REGION_L2:   return adr - (`SOC_DRAM_BASE);
      REGION_UART: return adr - (`SOC_UART_BASE);
      REGION_CTRL: return adr - (`SOC_CTRL_BASE);
      default:     return '0;
    endcase
  endfunction

  function automatic soc_data_t byte_merge(input soc_data_t old_val, input soc_data_t new_val,
                                           input soc_sel_t sel);
    soc_data_t res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Expected {err, read data} for an access to adr
  function automatic logic [32:0] ref_response(input soc_addr_t adr);
    soc_addr_t ofs;
    ofs = offset_of(adr);
    case (region_of(adr))
      REGION_L2: return {1'b0, l2_shadow[ofs[11:2]]};
      REGION_UART: begin
        if (ofs >= 32'h40) begin
          return {1'b1, 32'h0};
        end
        return {1'b0, uart_shadow[ofs[5:2]]};
      end
      REGION_CTRL: begin
        case (ofs)
          `CTRL_EXIT_OFS:      return {1'b0, ctrl_shadow[0]};
          `CTRL_HWCNT_OFS:     return {1'b0, ctrl_shadow[1]};
          `CTRL_EVENT_OFS:     return {1'b0, ctrl_shadow[2]};
          `CTRL_DRAM_BASE_OFS: return {1'b0, 32'h8000_0000};
          `CTRL_DRAM_END_OFS:  return {1'b0, 32'h8000_1000};
          default:             return 33'h0;
        endcase
      end
      default: return {1'b1, 32'h0};
    endcase
  endfunction

  function automatic void apply_write(input soc_addr_t adr, input soc_data_t dat,
                                      input soc_sel_t sel);
    soc_addr_t ofs;
    ofs = offset_of(adr);
    case (region_of(adr))
      REGION_L2: begin
        l2_shadow[ofs[11:2]] = byte_merge(l2_shadow[ofs[11:2]], dat, sel);
      end
      // UART registers are whole words
      REGION_UART: begin
        if (ofs < 32'h40) begin
          uart_shadow[ofs[5:2]] = dat;
        end
      end
      REGION_CTRL: begin
        if (ofs == `CTRL_EXIT_OFS || ofs == `CTRL_HWCNT_OFS || ofs == `CTRL_EVENT_OFS) begin
          ctrl_shadow[ofs[3:2]] = byte_merge(ctrl_shadow[ofs[3:2]], dat, sel);
        end
      end
      default: ;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus and checking
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string msg);
    errors++;
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input soc_data_t exp, input soc_data_t act);
    assert (act === exp)
      else stop_on_error($sformatf("error: %s expected %h actual %h", name, exp, act));
  endtask

  // One Wishbone classic transfer, held until ack or err
  task automatic wb_xfer(input logic we, input soc_addr_t adr, input soc_data_t dat,
                         input soc_sel_t sel);
    logic [32:0] resp;
    @(negedge clk);
    resp       = ref_response(adr);
    wb_cyc     = 1'b1;
    wb_stb     = 1'b1;
    wb_we      = we;
    wb_adr     = adr;
    wb_wdat    = dat;
    wb_sel     = sel;
    stall_cnt  = 0;
    psel_cnt   = 0;
    act_cycles = 0;
    do begin
      @(negedge clk);
      act_cycles++;
    end while (!wb_ack && !wb_err);
    act_ack  = wb_ack;
    act_err  = wb_err;
    act_data = wb_rdat;
    // Master samples the pulse on the next rising edge, then releases
    @(negedge clk);
    act_late   = wb_ack | wb_err;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    exp_err    = resp[32];
    exp_data   = resp[31:0];
    exp_psel   = (region_of(adr) == REGION_UART);
    exp_cycles = exp_psel ? 3 + stall_cnt : 1;
    xfer_we    = we;
    xfer_adr   = adr;
    if (we && !resp[32]) begin
      apply_write(adr, dat, sel);
    end
    -> xfer_done;
  endtask

  always @(xfer_done) begin
    check_value("wb_err_o", exp_err, act_err);
    check_value("wb_ack_o", !exp_err, act_ack);
    if (!xfer_we && !exp_err) begin
      check_value("wb_dat_o", exp_data, act_data);
    end
    assert (act_cycles == exp_cycles)
      else stop_on_error($sformatf("response for address %h came after %0d cycles, not %0d",
                                   xfer_adr, act_cycles, exp_cycles));
    assert (!act_late)
      else stop_on_error($sformatf("response for address %h lasted more than one cycle",
                                   xfer_adr));
    assert (exp_psel || psel_cnt == 0)
      else stop_on_error($sformatf("APB select rose for address %h outside the UART region",
                                   xfer_adr));
    check_value("exit_o", ctrl_shadow[0], exit_val);
    check_value("hw_cnt_en_o", ctrl_shadow[1], hw_cnt_en);
    check_value("event_trigger_o", ctrl_shadow[2], event_trigger);
  end

  initial begin
    int unsigned idx;
    int unsigned written[$];
    soc_sel_t    sel;
    void'($urandom(32'h495d_7f63));
    clk     = 1'b0;
    arst_n  = 1'b0;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
    wb_adr  = '0;
    wb_wdat = '0;
    wb_sel  = '0;
    for (int i = 0; i < `SOC_L2_WORDS; i++) begin
      l2_valid[i] = 1'b0;
    end
    for (int i = 0; i < 16; i++) begin
      uart_shadow[i] = 32'hA000_0000 | (i << 2);
    end
    for (int i = 0; i < 3; i++) begin
      ctrl_shadow[i] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Reset state and memory map constants
    check_value("exit_o", '0, exit_val);
    check_value("hw_cnt_en_o", '0, hw_cnt_en);
    check_value("event_trigger_o", '0, event_trigger);
    check_value("wb_ack_o", '0, wb_ack);
    check_value("wb_err_o", '0, wb_err);
    check_value("uart_psel_o", '0, uart_psel);
    check_value("uart_penable_o", '0, uart_penable);
    wb_xfer(1'b0, `SOC_CTRL_BASE + `CTRL_DRAM_BASE_OFS, '0, 4'hF);
    wb_xfer(1'b0, `SOC_CTRL_BASE + `CTRL_DRAM_END_OFS, '0, 4'hF);

    // L2, first write to a word is a full word
    for (int n = 0; n < L2_OPS; n++) begin
      idx = ($urandom % 2) ? $urandom % 32 : $urandom % `SOC_L2_WORDS;
      sel = l2_valid[idx] ? soc_sel_t'($urandom) : 4'hF;
      if (!l2_valid[idx]) begin
        l2_valid[idx] = 1'b1;
        written.push_back(idx);
      end
      wb_xfer(1'b1, `SOC_DRAM_BASE + (idx << 2), $urandom, sel);
    end
    foreach (written[i]) begin
      wb_xfer(1'b0, `SOC_DRAM_BASE + (written[i] << 2), '0, 4'hF);
    end

    // Control registers
    for (int n = 0; n < 12; n++) begin
      wb_xfer(1'b1, `SOC_CTRL_BASE + (n % 3) * 4, $urandom, soc_sel_t'($urandom));
      wb_xfer(1'b0, `SOC_CTRL_BASE + (n % 3) * 4, '0, 4'hF);
    end
    wb_xfer(1'b1, `SOC_CTRL_BASE + `CTRL_DRAM_BASE_OFS, 32'hFFFF_FFFF, 4'hF);
    wb_xfer(1'b1, `SOC_CTRL_BASE + `CTRL_DRAM_END_OFS, 32'h1234_5678, 4'hF);
    wb_xfer(1'b1, `SOC_CTRL_BASE + 32'h14, 32'hDEAD_BEEF, 4'hF);
    wb_xfer(1'b1, `SOC_CTRL_BASE + 32'h2, 32'h5555_AAAA, 4'hF);
    wb_xfer(1'b0, `SOC_CTRL_BASE + `CTRL_DRAM_BASE_OFS, '0, 4'hF);
    wb_xfer(1'b0, `SOC_CTRL_BASE + `CTRL_DRAM_END_OFS, '0, 4'hF);
    wb_xfer(1'b0, `SOC_CTRL_BASE + 32'h14, '0, 4'hF);

    // UART through APB
    for (int i = 0; i < 16; i++) begin
      wb_xfer(1'b0, `SOC_UART_BASE + i * 4, '0, 4'hF);
    end
    for (int i = 0; i < 16; i++) begin
      wb_xfer(1'b1, `SOC_UART_BASE + i * 4, $urandom, soc_sel_t'($urandom));
    end
    for (int i = 0; i < 16; i++) begin
      wb_xfer(1'b0, `SOC_UART_BASE + i * 4, '0, 4'hF);
    end
    wb_xfer(1'b0, `SOC_UART_BASE + 32'h40, '0, 4'hF);
    wb_xfer(1'b1, `SOC_UART_BASE + 32'h7C, 32'h0BAD_0BAD, 4'hF);
    wb_xfer(1'b0, `SOC_UART_BASE + 32'hFFC, '0, 4'hF);
    wb_xfer(1'b0, `SOC_UART_BASE + 32'h3C, '0, 4'hF);

    // Unmapped space
    wb_xfer(1'b0, 32'h0000_0000, '0, 4'hF);
    wb_xfer(1'b1, `SOC_DRAM_BASE + `SOC_DRAM_LEN, 32'h1111_2222, 4'hF);
    wb_xfer(1'b0, `SOC_UART_BASE + `SOC_UART_LEN, '0, 4'hF);
    wb_xfer(1'b1, `SOC_CTRL_BASE + `SOC_CTRL_LEN, 32'h3333_4444, 4'hF);
    wb_xfer(1'b0, 32'hFFFF_FFFC, '0, 4'hF);

    @(negedge clk);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
